/* dx_pkg.sv */
/*
 * Shared widths, opcodes and decoded-instruction types for the decode to
 * execute stage. Compile this file before the RTL and the testbench.
 */

package dx_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int OPERAND_WIDTH   = 32;
  localparam int RF_ADDR_WIDTH   = 5;
  localparam int OPCODE_WIDTH    = 6;
  localparam int IMM_WIDTH       = 26;
  localparam int IMM16_WIDTH     = 16;
  localparam int IMM_UPPER_WIDTH = IMM_WIDTH - IMM16_WIDTH;

  // Fall-through step past a branch and its delay slot
  localparam logic [OPERAND_WIDTH-1:0] DELAY_SLOT_BYTES = 32'd8;

  ////////////////////
  // Major opcodes
  ////////////////////

  localparam logic [OPCODE_WIDTH-1:0] OPCODE_J     = 6'h00;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_JAL   = 6'h01;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_BNF   = 6'h03;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_BF    = 6'h04;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_NOP   = 6'h05;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_RFE   = 6'h09;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_JR    = 6'h11;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_JALR  = 6'h12;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_LWZ   = 6'h21;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_MFSPR = 6'h2d;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_SWA   = 6'h33;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_SW    = 6'h35;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_ALU   = 6'h38;

  ////////////////////
  // Types
  ////////////////////

  typedef struct packed {
    logic rf_wb;
    logic alu;
    logic setflag;
    logic jbr;
    logic jr;
    logic jal;
    logic bf;
    logic bnf;
    logic brcond;
    logic branch;
    logic lsu_load;
    logic lsu_store;
    logic lsu_atomic;
    logic mfspr;
    logic mtspr;
    logic rfe;
  } dx_ops_t;

  // The 26-bit immediate field is a jump offset for l.j/l.bf,
  // and an upper part plus imm16 for everything else
  typedef union packed {
    logic signed [IMM_WIDTH-1:0] flat;
    struct packed {
      logic [IMM_UPPER_WIDTH-1:0] imm_upper;
      logic [IMM16_WIDTH-1:0]     imm16;
    } split;
  } dx_imm_u;

  typedef struct packed {
    logic ibus_err;
    logic illegal;
    logic syscall;
    logic trap;
    logic ibus_align;
  } dx_except_t;

  typedef struct packed {
    logic [OPERAND_WIDTH-1:0] pc;
    dx_ops_t                  ops;
    logic [OPCODE_WIDTH-1:0]  opc_insn;
    logic [RF_ADDR_WIDTH-1:0] rfd_adr;
    logic [RF_ADDR_WIDTH-1:0] rfa_adr;
    logic [RF_ADDR_WIDTH-1:0] rfb_adr;
    dx_imm_u                  imm;
    logic [OPERAND_WIDTH-1:0] immediate;
    logic                     immediate_sel;
    dx_except_t               except;
  } dx_decode_t;

  // What the control stage reports back for interlocks
  typedef struct packed {
    logic                     op_lsu_load;
    logic                     op_mfspr;
    logic [RF_ADDR_WIDTH-1:0] rfd_adr;
  } dx_ctrl_t;

  typedef struct packed {
    logic [OPERAND_WIDTH-1:0] pc;
    dx_ops_t                  ops;
    logic [OPCODE_WIDTH-1:0]  opc_insn;
    logic [RF_ADDR_WIDTH-1:0] rfd_adr;
    dx_imm_u                  imm;
    logic [OPERAND_WIDTH-1:0] immediate;
    logic                     immediate_sel;
    dx_except_t               except;
    logic [OPERAND_WIDTH-1:0] jal_result;
  } dx_execute_t;

endpackage

/* logic/dx_hazard_unit.sv */
/*
 * Register interlock detection between decode and the execute and control
 * stages. Produces the decode bubble and tells the branch unit when a jump
 * to register has its operand available.
 */

`timescale 1ns/1ps

module dx_hazard_unit (
  input  logic                padv_i,
  input  dx_pkg::dx_decode_t  decode_i,
  input  dx_pkg::dx_ctrl_t    ctrl_i,
  input  dx_pkg::dx_execute_t execute_i,
  output logic                decode_bubble_o,
  output logic                branch_to_reg_o
);

  import dx_pkg::*;

  logic rfa_match_exec;
  logic rfb_match_exec;
  logic exec_late_result;
  logic use_hazard;
  logic ctrl_late_result;
  logic jr_ctrl_conflict;
  logic jr_exec_conflict;
  logic jr_blocked;
  logic atomic_store;

  ////////////////////
  // Execute stage
  ////////////////////

  assign rfa_match_exec = (decode_i.rfa_adr == execute_i.rfd_adr);
  assign rfb_match_exec = (decode_i.rfb_adr == execute_i.rfd_adr);

  // Loads and mfspr only have their result in the control stage
  assign exec_late_result = execute_i.ops.lsu_load | execute_i.ops.mfspr;

  assign use_hazard = exec_late_result & (rfa_match_exec | rfb_match_exec);

  ////////////////////
  // Jump to register
  ////////////////////

  // Target register still being produced by a load or mfspr in control
  assign ctrl_late_result = ctrl_i.op_lsu_load | ctrl_i.op_mfspr;
  assign jr_ctrl_conflict = ctrl_late_result & (decode_i.rfb_adr == ctrl_i.rfd_adr);

  // Any write back from execute is not forwardable to the branch target yet
  assign jr_exec_conflict = execute_i.ops.rf_wb & rfb_match_exec;

  assign jr_blocked = decode_i.ops.jr & (jr_ctrl_conflict | jr_exec_conflict);

  assign branch_to_reg_o = decode_i.ops.jr & ~(jr_ctrl_conflict | jr_exec_conflict);

  ////////////////////
  // Bubble
  ////////////////////

  // Atomic store must finish before the next instruction issues
  assign atomic_store = execute_i.ops.lsu_store & execute_i.ops.lsu_atomic;

  // rfe stalls fetch while it travels up to the control stage
  assign decode_bubble_o = padv_i & (use_hazard |
                                     jr_blocked |
                                     atomic_store |
                                     decode_i.ops.rfe);

endmodule

/* logic/dx_branch_unit.sv */
/*
 * Early branch detection in decode. Computes the taken decision and target
 * for immediate and register jumps, the misaligned target exception, the
 * address after the delay slot and the target used on a mispredict.
 */

`timescale 1ns/1ps

module dx_branch_unit (
  input  logic                                pipeline_flush_i,
  input  logic                                predicted_flag_i,
  input  dx_pkg::dx_decode_t                  decode_i,
  input  logic                                branch_to_reg_i,
  input  dx_pkg::dx_execute_t                 execute_i,
  input  logic                                execute_bubble_i,
  input  logic [dx_pkg::OPERAND_WIDTH-1:0]    decode_rfb_i,
  input  logic [dx_pkg::OPERAND_WIDTH-1:0]    execute_rfb_i,
  output logic                                decode_branch_o,
  output logic [dx_pkg::OPERAND_WIDTH-1:0]    branch_target_o,
  output logic                                except_ibus_align_o,
  output logic [dx_pkg::OPERAND_WIDTH-1:0]    next_pc_o,
  output logic [dx_pkg::OPERAND_WIDTH-1:0]    mispredict_target_o
);

  import dx_pkg::*;

  localparam int SEXT_BITS = OPERAND_WIDTH - IMM_WIDTH - 2;

  logic                     unconditional;
  logic                     flag_matches;
  logic                     branch_to_imm;
  logic [OPERAND_WIDTH-1:0] imm_offset;
  logic [OPERAND_WIDTH-1:0] imm_target;
  logic [OPERAND_WIDTH-1:0] reg_target;
  logic                     use_exec_rfb;
  logic                     predict_taken_miss;

  ////////////////////
  // Immediate jumps
  ////////////////////

  // l.j and l.jal have opcode bits 2:1 clear
  assign unconditional = ~(|decode_i.opc_insn[2:1]);

  // Bit 2 separates l.bf from l.bnf
  assign flag_matches = (decode_i.opc_insn[2] == predicted_flag_i);

  assign branch_to_imm = decode_i.ops.jbr & (unconditional | flag_matches);

  // Word offset, sign extended
  assign imm_offset = {{SEXT_BITS{decode_i.imm.flat[IMM_WIDTH-1]}},
                       decode_i.imm.flat,
                       2'b00};

  assign imm_target = decode_i.pc + imm_offset;

  ////////////////////
  // Register jumps
  ////////////////////

  // After a bubble the producing instruction has moved on, so the
  // operand is read from the execute side of the register file
  assign use_exec_rfb = execute_bubble_i | execute_i.ops.jr;
  assign reg_target   = use_exec_rfb ? execute_rfb_i : decode_rfb_i;

  ////////////////////
  // Decision
  ////////////////////

  assign decode_branch_o = (branch_to_imm | branch_to_reg_i) & ~pipeline_flush_i;

  assign branch_target_o = branch_to_imm ? imm_target : reg_target;

  assign except_ibus_align_o = decode_branch_o & (|branch_target_o[1:0]);

  assign next_pc_o = decode_i.pc + DELAY_SLOT_BYTES;

  // Predicted not taken but the branch may go, so the recovery path is
  // the branch target; otherwise recovery falls through the delay slot
  assign predict_taken_miss = (decode_i.ops.bf & ~predicted_flag_i) |
                              (decode_i.ops.bnf & predicted_flag_i);

  assign mispredict_target_o = predict_taken_miss ? imm_target : next_pc_o;

endmodule

/* logic/dx_stage_reg.sv */
/*
 * Decode to execute pipeline register. Loads on the advance strobe, clears
 * control state on flush and turns the instruction into a NOP on a bubble,
 * letting rfe through so it can reach the control stage.
 */

`timescale 1ns/1ps

module dx_stage_reg (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             padv_i,
  input  logic                             pipeline_flush_i,
  input  logic                             decode_bubble_i,
  input  dx_pkg::dx_decode_t               decode_i,
  input  logic                             except_ibus_align_i,
  input  logic [dx_pkg::OPERAND_WIDTH-1:0] next_pc_i,
  input  logic [dx_pkg::OPERAND_WIDTH-1:0] mispredict_target_i,
  input  logic                             predicted_flag_i,
  output dx_pkg::dx_execute_t              execute_o,
  output logic                             execute_bubble_o,
  output logic                             decode_valid_o,
  output logic                             execute_predicted_flag_o,
  output logic [dx_pkg::OPERAND_WIDTH-1:0] execute_mispredict_target_o
);

  import dx_pkg::*;

  dx_ops_t                  ops_next;
  logic [OPCODE_WIDTH-1:0]  opc_next;
  dx_except_t               except_next;

  dx_ops_t                  ops_q;
  logic [OPCODE_WIDTH-1:0]  opc_q;
  dx_except_t               except_q;
  logic                     bubble_q;
  logic                     valid_q;

  logic [OPERAND_WIDTH-1:0] pc_q;
  logic [RF_ADDR_WIDTH-1:0] rfd_adr_q;
  dx_imm_u                  imm_q;
  logic [OPERAND_WIDTH-1:0] immediate_q;
  logic                     immediate_sel_q;
  logic [OPERAND_WIDTH-1:0] jal_result_q;
  logic                     pred_flag_q;
  logic [OPERAND_WIDTH-1:0] mispredict_target_q;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    ops_next = decode_i.ops;
    opc_next = decode_i.opc_insn;
    if (decode_bubble_i) begin
      // Bubble keeps rfe alive, everything else becomes a NOP
      ops_next     = '0;
      ops_next.rfe = decode_i.ops.rfe;
      opc_next     = OPCODE_NOP;
    end
  end

  // Misaligned target replaces the unused incoming flag
  always_comb begin
    except_next            = decode_i.except;
    except_next.ibus_align = except_ibus_align_i;
  end

  ////////////////////
  // Control state
  ////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ops_q    <= '0;
      opc_q    <= OPCODE_NOP;
      bubble_q <= 1'b0;
    end else if (pipeline_flush_i) begin
      ops_q    <= '0;
      opc_q    <= OPCODE_NOP;
      bubble_q <= 1'b0;
    end else if (padv_i) begin
      ops_q    <= ops_next;
      opc_q    <= opc_next;
      bubble_q <= decode_bubble_i;
    end
  end

  // Exceptions survive a flush and load on every advance
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      except_q <= '0;
    end else if (padv_i) begin
      except_q <= except_next;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= padv_i;
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  always_ff @(posedge clk) begin
    if (padv_i) begin
      pc_q            <= decode_i.pc;
      rfd_adr_q       <= decode_i.rfd_adr;
      imm_q           <= decode_i.imm;
      immediate_q     <= decode_i.immediate;
      immediate_sel_q <= decode_i.immediate_sel;
      // Link address for l.jal/l.jalr
      jal_result_q    <= next_pc_i;
    end
  end

  // Prediction pair only matters for conditional branches
  always_ff @(posedge clk) begin
    if (padv_i & decode_i.ops.brcond) begin
      pred_flag_q         <= predicted_flag_i;
      mispredict_target_q <= mispredict_target_i;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign execute_o = '{pc:            pc_q,
                       ops:           ops_q,
                       opc_insn:      opc_q,
                       rfd_adr:       rfd_adr_q,
                       imm:           imm_q,
                       immediate:     immediate_q,
                       immediate_sel: immediate_sel_q,
                       except:        except_q,
                       jal_result:    jal_result_q};

  assign execute_bubble_o            = bubble_q;
  assign decode_valid_o              = valid_q;
  assign execute_predicted_flag_o    = pred_flag_q;
  assign execute_mispredict_target_o = mispredict_target_q;

endmodule

/* logic/decode_execute.sv */
/*
 * Decode to execute stage of the in-order pipeline. Connects the hazard
 * unit and the branch unit to the stage register; the registered execute
 * view feeds back into both units.
 */

`timescale 1ns/1ps

module decode_execute (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             padv_i,
  input  logic                             pipeline_flush_i,
  input  logic                             predicted_flag_i,
  input  dx_pkg::dx_decode_t               decode_i,
  input  dx_pkg::dx_ctrl_t                 ctrl_i,
  input  logic [dx_pkg::OPERAND_WIDTH-1:0] decode_rfb_i,
  input  logic [dx_pkg::OPERAND_WIDTH-1:0] execute_rfb_i,
  output dx_pkg::dx_execute_t              execute_o,
  output logic                             execute_predicted_flag_o,
  output logic [dx_pkg::OPERAND_WIDTH-1:0] execute_mispredict_target_o,
  output logic                             decode_branch_o,
  output logic [dx_pkg::OPERAND_WIDTH-1:0] decode_branch_target_o,
  output logic                             decode_bubble_o,
  output logic                             execute_bubble_o,
  output logic                             decode_valid_o
);

  import dx_pkg::*;

  logic                     decode_bubble;
  logic                     branch_to_reg;
  logic                     decode_branch;
  logic [OPERAND_WIDTH-1:0] branch_target;
  logic                     except_ibus_align;
  logic [OPERAND_WIDTH-1:0] next_pc;
  logic [OPERAND_WIDTH-1:0] mispredict_target;
  dx_execute_t              execute;
  logic                     execute_bubble;

  dx_hazard_unit hazard_unit_inst (
    .padv_i          (padv_i),
    .decode_i        (decode_i),
    .ctrl_i          (ctrl_i),
    .execute_i       (execute),
    .decode_bubble_o (decode_bubble),
    .branch_to_reg_o (branch_to_reg)
  );

  dx_branch_unit branch_unit_inst (
    .pipeline_flush_i    (pipeline_flush_i),
    .predicted_flag_i    (predicted_flag_i),
    .decode_i            (decode_i),
    .branch_to_reg_i     (branch_to_reg),
    .execute_i           (execute),
    .execute_bubble_i    (execute_bubble),
    .decode_rfb_i        (decode_rfb_i),
    .execute_rfb_i       (execute_rfb_i),
    .decode_branch_o     (decode_branch),
    .branch_target_o     (branch_target),
    .except_ibus_align_o (except_ibus_align),
    .next_pc_o           (next_pc),
    .mispredict_target_o (mispredict_target)
  );

  dx_stage_reg stage_reg_inst (
    .clk                         (clk),
    .rst                         (rst),
    .padv_i                      (padv_i),
    .pipeline_flush_i            (pipeline_flush_i),
    .decode_bubble_i             (decode_bubble),
    .decode_i                    (decode_i),
    .except_ibus_align_i         (except_ibus_align),
    .next_pc_i                   (next_pc),
    .mispredict_target_i         (mispredict_target),
    .predicted_flag_i            (predicted_flag_i),
    .execute_o                   (execute),
    .execute_bubble_o            (execute_bubble),
    .decode_valid_o              (decode_valid_o),
    .execute_predicted_flag_o    (execute_predicted_flag_o),
    .execute_mispredict_target_o (execute_mispredict_target_o)
  );

  // Same-cycle decode outputs
  assign decode_bubble_o        = decode_bubble;
  assign decode_branch_o        = decode_branch;
  assign decode_branch_target_o = branch_target;

  // Registered execute view
  assign execute_o        = execute;
  assign execute_bubble_o = execute_bubble;

endmodule

/* verif/decode_execute_checker.sv */
/*
 * Concurrent assertions on the flush, bubble and valid rules of the decode
 * to execute stage. Bound into decode_execute from this file.
 */

`timescale 1ns/1ps

module decode_execute_checker (
  input logic            clk,
  input logic            rst,
  input logic            padv_i,
  input logic            pipeline_flush_i,
  input dx_pkg::dx_ops_t execute_ops_i,
  input logic            execute_bubble_i,
  input logic            decode_branch_i,
  input logic            decode_valid_i
);

  // A flush leaves no live op and no bubble behind it
  flush_clears_ops: assert property (@(posedge clk) disable iff (rst)
    pipeline_flush_i |=> (execute_ops_i == '0) && !execute_bubble_i)
    else $error("Flush did not clear the execute ops and bubble");

  valid_follows_padv: assert property (@(posedge clk) disable iff (rst)
    decode_valid_i == $past(padv_i))
    else $error("decode_valid_o does not follow padv_i by one cycle");

  no_branch_in_flush: assert property (@(posedge clk) disable iff (rst)
    pipeline_flush_i |-> !decode_branch_i)
    else $error("decode_branch_o raised during a flush");

endmodule

bind decode_execute decode_execute_checker checker_inst (
  .clk              (clk),
  .rst              (rst),
  .padv_i           (padv_i),
  .pipeline_flush_i (pipeline_flush_i),
  .execute_ops_i    (execute_o.ops),
  .execute_bubble_i (execute_bubble_o),
  .decode_branch_i  (decode_branch_o),
  .decode_valid_i   (decode_valid_o)
);

/* verif/decode_execute_tb.sv */
/*
 * Directed testbench for the decode to execute stage. Each test task drives
 * decode words into the DUT and checks the same-cycle and registered results.
 */

`timescale 1ns/1ps

module decode_execute_tb;

  import dx_pkg::*;

  localparam int ADV_TIMEOUT = 8;

  logic                     clk;
  logic                     rst;
  logic                     padv;
  logic                     pipeline_flush;
  logic                     predicted_flag;
  dx_decode_t               decode;
  dx_ctrl_t                 ctrl;
  logic [OPERAND_WIDTH-1:0] decode_rfb;
  logic [OPERAND_WIDTH-1:0] execute_rfb;
  dx_execute_t              execute;
  logic                     execute_predicted_flag;
  logic [OPERAND_WIDTH-1:0] execute_mispredict_target;
  logic                     decode_branch;
  logic [OPERAND_WIDTH-1:0] decode_branch_target;
  logic                     decode_bubble;
  logic                     execute_bubble;
  logic                     decode_valid;
  integer                   seed;

  decode_execute decode_execute_inst (
    .clk                         (clk),
    .rst                         (rst),
    .padv_i                      (padv),
    .pipeline_flush_i            (pipeline_flush),
    .predicted_flag_i            (predicted_flag),
    .decode_i                    (decode),
    .ctrl_i                      (ctrl),
    .decode_rfb_i                (decode_rfb),
    .execute_rfb_i               (execute_rfb),
    .execute_o                   (execute),
    .execute_predicted_flag_o    (execute_predicted_flag),
    .execute_mispredict_target_o (execute_mispredict_target),
    .decode_branch_o             (decode_branch),
    .decode_branch_target_o      (decode_branch_target),
    .decode_bubble_o             (decode_bubble),
    .execute_bubble_o            (execute_bubble),
    .decode_valid_o              (decode_valid)
  );

  always #2 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
      stop_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic dx_decode_t blank_decode(input logic [31:0] pc);
    dx_decode_t d;
    d          = '0;
    d.pc       = pc;
    d.opc_insn = OPCODE_NOP;
    return d;
  endfunction

  // Word offset from the flat immediate, sign extended
  function automatic logic [31:0] imm_target(input dx_decode_t d);
    logic signed [31:0] words;
    words = {{6{d.imm.flat[25]}}, d.imm.flat};
    return d.pc + words * 32'sd4;
  endfunction

  // One advance edge, then wait for decode_valid_o
  task automatic advance();
    int cycles;
    padv   = 1'b1;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      padv           = 1'b0;
      pipeline_flush = 1'b0;
      cycles++;
    end while (!decode_valid && cycles < ADV_TIMEOUT);
    assert (decode_valid && cycles == 1) else
      stop_run("decode_valid_o did not rise one cycle after the advance");
  endtask

  task automatic run_branch(input logic [5:0] opc, input logic flag, input logic taken,
                            input logic [1:0] pc_low);
    dx_decode_t  d;
    logic [31:0] r;
    logic [31:0] exp_target;
    d             = blank_decode((rand_word() & ~32'h3) | {30'h0, pc_low});
    r             = rand_word();
    d.imm.flat    = r[25:0];
    d.opc_insn    = opc;
    d.ops.jbr     = 1'b1;
    d.ops.branch  = 1'b1;
    d.ops.bf      = (opc == OPCODE_BF);
    d.ops.bnf     = (opc == OPCODE_BNF);
    d.ops.brcond  = d.ops.bf | d.ops.bnf;
    d.ops.jal     = (opc == OPCODE_JAL);
    d.ops.rf_wb   = d.ops.jal;
    decode         = d;
    predicted_flag = flag;
    padv           = 1'b1;
    #1;
    check_hex("decode_branch_o", 32'(decode_branch), 32'(taken));
    if (taken) begin
      check_hex("decode_branch_target_o", decode_branch_target, imm_target(d));
    end
    advance();
    check_hex("execute_o.jal_result", execute.jal_result, d.pc + 32'd8);
    check_hex("execute_o.except.ibus_align", 32'(execute.except.ibus_align),
              32'(taken && pc_low != 2'b00));
    if (d.ops.brcond) begin
      // Recovery goes to the target only when the branch was predicted not taken
      if (!taken) begin
        exp_target = imm_target(d);
      end else begin
        exp_target = d.pc + 32'd8;
      end
      check_hex("execute_mispredict_target_o", execute_mispredict_target, exp_target);
      check_hex("execute_predicted_flag_o", 32'(execute_predicted_flag), 32'(flag));
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_and_advance();
    dx_decode_t  d;
    dx_execute_t held;
    logic [31:0] r;
    check_hex("execute_o.ops", 32'(execute.ops), 32'h0);
    check_hex("execute_o.opc_insn", 32'(execute.opc_insn), 32'(OPCODE_NOP));
    check_hex("execute_o.except", 32'(execute.except), 32'h0);
    check_hex("execute_bubble_o", 32'(execute_bubble), 32'h0);
    check_hex("decode_valid_o", 32'(decode_valid), 32'h0);
    d                  = blank_decode(rand_word() & ~32'h3);
    r                  = rand_word();
    d.ops.alu          = 1'b1;
    d.ops.rf_wb        = 1'b1;
    d.opc_insn         = OPCODE_ALU;
    d.rfd_adr          = r[4:0];
    d.rfa_adr          = r[9:5];
    d.rfb_adr          = r[14:10];
    d.immediate_sel    = r[15];
    r                  = rand_word();
    d.imm.flat         = r[25:0];
    d.immediate        = rand_word();
    d.except.illegal   = 1'b1;
    decode = d;
    advance();
    check_hex("execute_o.pc", execute.pc, d.pc);
    check_hex("execute_o.ops", 32'(execute.ops), 32'(d.ops));
    check_hex("execute_o.opc_insn", 32'(execute.opc_insn), 32'(d.opc_insn));
    check_hex("execute_o.rfd_adr", 32'(execute.rfd_adr), 32'(d.rfd_adr));
    check_hex("execute_o.imm", {6'h0, execute.imm}, {6'h0, d.imm});
    check_hex("execute_o.immediate", execute.immediate, d.immediate);
    check_hex("execute_o.immediate_sel", 32'(execute.immediate_sel), 32'(d.immediate_sel));
    check_hex("execute_o.except", 32'(execute.except), 32'(d.except));
    check_hex("execute_o.jal_result", execute.jal_result, d.pc + 32'd8);
    check_hex("execute_bubble_o", 32'(execute_bubble), 32'h0);
    // Stage holds while padv_i stays low
    held   = execute;
    decode = blank_decode(rand_word());
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    assert (execute === held) else stop_run("execute_o changed while padv_i was low");
    check_hex("decode_valid_o", 32'(decode_valid), 32'h0);
  endtask

  task automatic test_imm_branch();
    run_branch(OPCODE_J, 1'b1, 1'b1, 2'b00);
    run_branch(OPCODE_JAL, 1'b0, 1'b1, 2'b00);
    run_branch(OPCODE_BF, 1'b1, 1'b1, 2'b00);
    run_branch(OPCODE_BNF, 1'b0, 1'b1, 2'b00);
    run_branch(OPCODE_J, 1'b0, 1'b1, 2'b10);
  endtask

  task automatic test_mispredict();
    logic [31:0] kept;
    run_branch(OPCODE_BF, 1'b0, 1'b0, 2'b00);
    run_branch(OPCODE_BF, 1'b1, 1'b1, 2'b00);
    run_branch(OPCODE_BNF, 1'b1, 1'b0, 2'b00);
    run_branch(OPCODE_BNF, 1'b0, 1'b1, 2'b00);
    // A non-conditional advance leaves the prediction pair alone
    kept   = execute_mispredict_target;
    decode = blank_decode(rand_word());
    advance();
    check_hex("execute_mispredict_target_o", execute_mispredict_target, kept);
  endtask

  task automatic test_load_use();
    dx_decode_t  d;
    dx_ops_t     rfe_only;
    logic [31:0] r;
    logic [4:0]  rd;
    r               = rand_word();
    rd              = r[4:0] | 5'd1;
    d               = blank_decode(rand_word() & ~32'h3);
    d.ops.lsu_load  = 1'b1;
    d.ops.rf_wb     = 1'b1;
    d.opc_insn      = OPCODE_LWZ;
    d.rfd_adr       = rd;
    decode = d;
    advance();
    d           = blank_decode(rand_word() & ~32'h3);
    d.ops.alu   = 1'b1;
    d.ops.rf_wb = 1'b1;
    d.opc_insn  = OPCODE_ALU;
    d.rfa_adr   = rd;
    d.rfb_adr   = ~rd;
    decode = d;
    #1;
    check_hex("decode_bubble_o", 32'(decode_bubble), 32'h0);
    padv = 1'b1;
    #1;
    check_hex("decode_bubble_o", 32'(decode_bubble), 32'h1);
    advance();
    check_hex("execute_o.ops", 32'(execute.ops), 32'h0);
    check_hex("execute_o.opc_insn", 32'(execute.opc_insn), 32'(OPCODE_NOP));
    check_hex("execute_bubble_o", 32'(execute_bubble), 32'h1);
    // rfe bubbles itself but still reaches execute
    d          = blank_decode(rand_word() & ~32'h3);
    d.ops.rfe  = 1'b1;
    d.opc_insn = OPCODE_RFE;
    decode = d;
    padv   = 1'b1;
    #1;
    check_hex("decode_bubble_o", 32'(decode_bubble), 32'h1);
    advance();
    rfe_only     = '0;
    rfe_only.rfe = 1'b1;
    check_hex("execute_o.ops", 32'(execute.ops), 32'(rfe_only));
    check_hex("execute_bubble_o", 32'(execute_bubble), 32'h1);
  endtask

  task automatic test_reg_jump();
    dx_decode_t  d;
    logic [31:0] r;
    decode = blank_decode(32'h0);
    advance();
    r            = rand_word();
    d            = blank_decode(rand_word() & ~32'h3);
    d.ops.jr     = 1'b1;
    d.ops.branch = 1'b1;
    d.opc_insn   = OPCODE_JR;
    d.rfb_adr    = r[4:0];
    decode_rfb   = rand_word() & ~32'h3;
    execute_rfb  = rand_word() & ~32'h3;
    decode = d;
    padv   = 1'b1;
    #1;
    check_hex("decode_branch_o", 32'(decode_branch), 32'h1);
    check_hex("decode_branch_target_o", decode_branch_target, decode_rfb);
    check_hex("decode_bubble_o", 32'(decode_bubble), 32'h0);
    // Load in control still producing the jump register
    ctrl.op_lsu_load = 1'b1;
    ctrl.rfd_adr     = r[4:0];
    #1;
    check_hex("decode_branch_o", 32'(decode_branch), 32'h0);
    check_hex("decode_bubble_o", 32'(decode_bubble), 32'h1);
    advance();
    check_hex("execute_bubble_o", 32'(execute_bubble), 32'h1);
    ctrl = '0;
    padv = 1'b1;
    #1;
    check_hex("decode_branch_o", 32'(decode_branch), 32'h1);
    check_hex("decode_branch_target_o", decode_branch_target, execute_rfb);
    check_hex("decode_bubble_o", 32'(decode_bubble), 32'h0);
    advance();
  endtask

  task automatic test_flush();
    dx_decode_t  d;
    logic [31:0] r;
    d          = blank_decode(rand_word() & ~32'h3);
    d.ops.rfe  = 1'b1;
    d.opc_insn = OPCODE_RFE;
    decode = d;
    advance();
    check_hex("execute_bubble_o", 32'(execute_bubble), 32'h1);
    d                = blank_decode(rand_word() & ~32'h3);
    r                = rand_word();
    d.imm.flat       = r[25:0];
    d.ops.jbr        = 1'b1;
    d.ops.branch     = 1'b1;
    d.opc_insn       = OPCODE_J;
    d.except.illegal = 1'b1;
    d.except.syscall = 1'b1;
    decode         = d;
    pipeline_flush = 1'b1;
    padv           = 1'b1;
    #1;
    check_hex("decode_branch_o", 32'(decode_branch), 32'h0);
    advance();
    check_hex("execute_o.ops", 32'(execute.ops), 32'h0);
    check_hex("execute_o.opc_insn", 32'(execute.opc_insn), 32'(OPCODE_NOP));
    check_hex("execute_bubble_o", 32'(execute_bubble), 32'h0);
    check_hex("execute_o.except", 32'(execute.except), 32'(d.except));
    // The bound checker judges a flush on the edge after it
    @(posedge clk);
    #1;
  endtask

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    padv           = 1'b0;
    pipeline_flush = 1'b0;
    predicted_flag = 1'b0;
    decode         = blank_decode(32'h0);
    ctrl           = '0;
    decode_rfb     = '0;
    execute_rfb    = '0;
    seed           = 81968;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset_and_advance();
    test_imm_branch();
    test_mispredict();
    test_load_use();
    test_reg_jump();
    test_flush();
    $display("All tests passed!");
    $finish;
  end

endmodule

/* verilog.f */
dx_pkg.sv
logic/dx_hazard_unit.sv
logic/dx_branch_unit.sv
logic/dx_stage_reg.sv
logic/decode_execute.sv
verif/decode_execute_checker.sv
verif/decode_execute_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the decode to execute testbench with Verilator and runs it.
# Exit status is non-zero when the build fails or the simulation stops on an error.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
  --top-module decode_execute_tb -o decode_execute_sim \
  && ./obj_dir/decode_execute_sim \
  || exit 1
